// File: logic/matvec_pkg.sv
// Matrix and vector sizes, element types and load-sequence counts shared by the accelerator
`default_nettype none

package matvec_pkg;

  // --------------------------------------------------
  // Dimensions
  // --------------------------------------------------
  // Square matrix side, also the vector length
  localparam int DIM    = 16;
  // One element is a single byte
  localparam int ELEM_W = 8;

  // --------------------------------------------------
  // Element, vector and matrix types
  // --------------------------------------------------
  typedef logic [ELEM_W-1:0]         elem_t;
  // Element k at bits k*8 upward
  typedef logic [DIM*ELEM_W-1:0]     vec_t;
  // Element (row j, col k) is byte j*16+k
  typedef logic [DIM*DIM*ELEM_W-1:0] mat_t;

  // Host loads operands as 32-bit words
  localparam int MAT_WORDS  = (DIM * DIM * ELEM_W) / 32;
  localparam int VEC_WORDS  = (DIM * ELEM_W) / 32;
  // Matrix, then vector, then iteration count
  localparam int LOAD_WORDS = MAT_WORDS + VEC_WORDS + 1;

  typedef logic [6:0]  load_idx_t;
  typedef logic [3:0]  row_idx_t;
  typedef logic [31:0] iter_t;

endpackage

`default_nettype wire

// File: logic/axil_pkg.sv
// AXI-Lite widths, response codes and the register map of the accelerator's control port
`default_nettype none

package axil_pkg;

  // Bus field types
  typedef logic [31:0] addr_t;
  typedef logic [31:0] word_t;
  typedef logic [1:0]  resp_t;

  // Only OKAY is ever returned
  localparam resp_t RESP_OKAY = 2'b00;

  // Single data register for loads and result reads
  localparam addr_t DATA_REG_ADDR = 32'h0000_0500;
  // Returned for every other read address
  localparam word_t UNIMPL_VALUE  = 32'hDEAD_BEEF;

  // Selects one 32-bit word of the 128-bit result
  typedef logic [1:0] word_sel_t;

endpackage

`default_nettype wire

// File: logic/axil_slave_port.sv
// AXI-Lite slave with single-beat write and read handshakes, decodes the data register address
`default_nettype none

module axil_slave_port (
  input  logic            clk_main_a0,
  input  logic            rst_main_n_sync,
  input  logic            awvalid,
  input  axil_pkg::addr_t awaddr,
  output logic            awready,
  input  logic            wvalid,
  input  axil_pkg::word_t wdata,
  input  logic [3:0]      wstrb,
  output logic            wready,
  output logic            bvalid,
  output axil_pkg::resp_t bresp,
  input  logic            bready,
  input  logic            arvalid,
  input  axil_pkg::addr_t araddr,
  output logic            arready,
  output logic            rvalid,
  output axil_pkg::word_t rdata,
  output axil_pkg::resp_t rresp,
  input  logic            rready,
  output logic            data_wr,
  output axil_pkg::word_t data_wdata,
  output logic            data_rd,
  input  axil_pkg::word_t rd_word
);
  import axil_pkg::*;

  logic  wr_active;
  addr_t wr_addr;
  logic  rd_pending;
  addr_t rd_addr;
  logic  rd_hit;

  // --------------------------------------------------
  // Write channel
  // --------------------------------------------------
  // Accept a new address only when idle
  assign awready = !wr_active;
  // Data beat taken once per write, blocked while response is out
  assign wready  = wr_active && wvalid && !bvalid;
  // wstrb not decoded, every write counts as a full word
  assign bresp   = RESP_OKAY;

  always_ff @(posedge clk_main_a0) begin
    if (!rst_main_n_sync) begin
      wr_active <= 1'b0;
      bvalid    <= 1'b0;
    end else begin
      // Response accepted ends the write
      if (bvalid && bready) begin
        wr_active <= 1'b0;
        bvalid    <= 1'b0;
      end else begin
        if (awvalid && !wr_active) begin
          wr_active <= 1'b1;
        end
        if (wready) begin
          bvalid <= 1'b1;
        end
      end
    end
  end

  // Address capture
  always_ff @(posedge clk_main_a0) begin
    if (awvalid && !wr_active) begin
      wr_addr <= awaddr;
    end
  end

  // Data register strobe, other addresses fall through silently
  assign data_wr    = wready && (wr_addr == DATA_REG_ADDR);
  assign data_wdata = wdata;

  // --------------------------------------------------
  // Read channel
  // --------------------------------------------------
  assign arready = !rd_pending && !rvalid;
  assign rresp   = RESP_OKAY;
  assign rd_hit  = (rd_addr == DATA_REG_ADDR);
  // Pointer advances as the word moves into rdata
  assign data_rd = rd_pending && rd_hit;

  always_ff @(posedge clk_main_a0) begin
    if (!rst_main_n_sync) begin
      rd_pending <= 1'b0;
      rvalid     <= 1'b0;
    end else begin
      rd_pending <= arvalid && arready;
      if (rd_pending) begin
        rvalid <= 1'b1;
      end else if (rvalid && rready) begin
        rvalid <= 1'b0;
      end
    end
  end

  // Read address and data payload
  always_ff @(posedge clk_main_a0) begin
    if (arvalid && arready) begin
      rd_addr <= araddr;
    end
    // Held stable until rready
    if (rd_pending) begin
      rdata <= rd_hit ? rd_word : UNIMPL_VALUE;
    end
  end

endmodule

`default_nettype wire

// File: logic/operand_loader.sv
// Steers data register writes into matrix, vector and iteration count, then pulses start
`default_nettype none

module operand_loader (
  input  logic              clk_main_a0,
  input  logic              rst_main_n_sync,
  input  logic              data_wr,
  input  axil_pkg::word_t   data_wdata,
  output matvec_pkg::mat_t  mat,
  output matvec_pkg::vec_t  vec,
  output matvec_pkg::iter_t iterations,
  output logic              start
);
  import matvec_pkg::*;
  import axil_pkg::*;

  load_idx_t load_idx;
  iter_t     iter_q;
  logic      mat_phase;
  logic      vec_phase;
  logic      last_word;

  // --------------------------------------------------
  // Load sequence decode
  // --------------------------------------------------
  // Words 0..63 matrix
  assign mat_phase = (load_idx < load_idx_t'(MAT_WORDS));
  // Words 64..67 vector
  assign vec_phase = !mat_phase && (load_idx < load_idx_t'(MAT_WORDS + VEC_WORDS));
  // Word 68 is the iteration count
  assign last_word = (load_idx == load_idx_t'(LOAD_WORDS - 1));

  // Kick the engine on the count write itself
  assign start = data_wr && last_word;
  // Count is live on the start cycle, held afterwards
  assign iterations = start ? iter_t'(data_wdata) : iter_q;

  // Counter
  always_ff @(posedge clk_main_a0) begin
    if (!rst_main_n_sync) begin
      load_idx <= '0;
    end else if (data_wr) begin
      if (last_word) begin
        load_idx <= '0;
      end else begin
        load_idx <= load_idx + 1'b1;
      end
    end
  end

  // Operand storage
  always_ff @(posedge clk_main_a0) begin
    if (!rst_main_n_sync) begin
      iter_q <= '0;
    end else if (start) begin
      iter_q <= iter_t'(data_wdata);
    end
  end

  always_ff @(posedge clk_main_a0) begin
    if (data_wr && mat_phase) begin
      // Low byte of each word lands on the lower element
      mat[load_idx * $bits(word_t) +: $bits(word_t)] <= data_wdata;
    end
    if (data_wr && vec_phase) begin
      vec[(load_idx - load_idx_t'(MAT_WORDS)) * $bits(word_t) +: $bits(word_t)] <= data_wdata;
    end
  end

endmodule

`default_nettype wire

// File: logic/matvec_engine.sv
// Iterative matrix-vector multiply, one output element per cycle, result held between runs
`default_nettype none

module matvec_engine (
  input  logic              clk_main_a0,
  input  logic              rst_main_n_sync,
  input  logic              start,
  input  matvec_pkg::mat_t  mat,
  input  matvec_pkg::vec_t  vec,
  input  matvec_pkg::iter_t iterations,
  output logic              busy,
  output matvec_pkg::vec_t  result
);
  import matvec_pkg::*;

  vec_t     work_vec;
  vec_t     next_vec;
  vec_t     next_vec_upd;
  row_idx_t row;
  iter_t    iter_left;
  elem_t    row_sum;
  logic     last_row;

  // --------------------------------------------------
  // Row dot product
  // --------------------------------------------------
  // Products and sum both wrap at 8 bits
  always_comb begin
    row_sum = '0;
    for (int k = 0; k < DIM; k++) begin
      row_sum = row_sum + elem_t'(mat[(int'(row) * DIM + k) * ELEM_W +: ELEM_W]
                                  * work_vec[k * ELEM_W +: ELEM_W]);
    end
  end

  // Partial next vector with the current row filled in
  always_comb begin
    next_vec_upd = next_vec;
    next_vec_upd[row * ELEM_W +: ELEM_W] = row_sum;
  end

  assign last_row = (row == row_idx_t'(DIM - 1));

  // --------------------------------------------------
  // Control
  // --------------------------------------------------
  always_ff @(posedge clk_main_a0) begin
    if (!rst_main_n_sync) begin
      busy      <= 1'b0;
      row       <= '0;
      iter_left <= '0;
      result    <= '0;
    end else if (!busy) begin
      // Zero count leaves everything as it was
      if (start && (iterations != '0)) begin
        busy      <= 1'b1;
        row       <= '0;
        iter_left <= iterations;
      end
    end else begin
      // Row index wraps back to 0 after row 15
      row <= row + 1'b1;
      if (last_row) begin
        result    <= next_vec_upd;
        iter_left <= iter_left - 1'b1;
        // Final pass done
        if (iter_left == iter_t'(1)) begin
          busy <= 1'b0;
        end
      end
    end
  end

  // Working vectors
  always_ff @(posedge clk_main_a0) begin
    if (!busy) begin
      // Private copy, later loader writes do not disturb a run
      if (start) begin
        work_vec <= vec;
      end
    end else begin
      next_vec <= next_vec_upd;
      // Chain the iterations
      if (last_row) begin
        work_vec <= next_vec_upd;
      end
    end
  end

endmodule

`default_nettype wire

// File: logic/result_reader.sv
// Word pointer that presents one 32-bit slice of the result per data register read
`default_nettype none

module result_reader (
  input  logic             clk_main_a0,
  input  logic             rst_main_n_sync,
  input  logic             data_rd,
  input  matvec_pkg::vec_t result,
  output axil_pkg::word_t  rd_word
);
  import axil_pkg::*;

  word_sel_t word_sel;

  // --------------------------------------------------
  // Pointer
  // --------------------------------------------------
  // Natural 2-bit wrap after word 3
  always_ff @(posedge clk_main_a0) begin
    if (!rst_main_n_sync) begin
      word_sel <= '0;
    end else if (data_rd) begin
      word_sel <= word_sel + 1'b1;
    end
  end

  // Current word, low word first
  assign rd_word = result[word_sel * $bits(word_t) +: $bits(word_t)];

endmodule

`default_nettype wire

// File: logic/matvec_accel_top.sv
// Accelerator top level, connects the AXI-Lite port, operand loader, engine and result reader
`default_nettype none

module matvec_accel_top (
  input  logic            clk_main_a0,
  input  logic            rst_main_n_sync,
  input  logic            awvalid,
  input  axil_pkg::addr_t awaddr,
  output logic            awready,
  input  logic            wvalid,
  input  axil_pkg::word_t wdata,
  input  logic [3:0]      wstrb,
  output logic            wready,
  output logic            bvalid,
  output axil_pkg::resp_t bresp,
  input  logic            bready,
  input  logic            arvalid,
  input  axil_pkg::addr_t araddr,
  output logic            arready,
  output logic            rvalid,
  output axil_pkg::word_t rdata,
  output axil_pkg::resp_t rresp,
  input  logic            rready,
  output logic            busy
);
  import matvec_pkg::*;
  import axil_pkg::*;

  // Bus port to loader and reader
  logic  data_wr;
  word_t data_wdata;
  logic  data_rd;
  word_t rd_word;
  // Loader to engine
  mat_t  mat;
  vec_t  vec;
  iter_t iterations;
  logic  start;
  // Engine to reader
  vec_t  result;

  // --------------------------------------------------
  // Host interface
  // --------------------------------------------------
  axil_slave_port u_axil_slave_port (
    .clk_main_a0     (clk_main_a0),
    .rst_main_n_sync (rst_main_n_sync),
    .awvalid         (awvalid),
    .awaddr          (awaddr),
    .awready         (awready),
    .wvalid          (wvalid),
    .wdata           (wdata),
    .wstrb           (wstrb),
    .wready          (wready),
    .bvalid          (bvalid),
    .bresp           (bresp),
    .bready          (bready),
    .arvalid         (arvalid),
    .araddr          (araddr),
    .arready         (arready),
    .rvalid          (rvalid),
    .rdata           (rdata),
    .rresp           (rresp),
    .rready          (rready),
    .data_wr         (data_wr),
    .data_wdata      (data_wdata),
    .data_rd         (data_rd),
    .rd_word         (rd_word)
  );

  // --------------------------------------------------
  // Datapath
  // --------------------------------------------------
  operand_loader u_operand_loader (
    .clk_main_a0     (clk_main_a0),
    .rst_main_n_sync (rst_main_n_sync),
    .data_wr         (data_wr),
    .data_wdata      (data_wdata),
    .mat             (mat),
    .vec             (vec),
    .iterations      (iterations),
    .start           (start)
  );

  matvec_engine u_matvec_engine (
    .clk_main_a0     (clk_main_a0),
    .rst_main_n_sync (rst_main_n_sync),
    .start           (start),
    .mat             (mat),
    .vec             (vec),
    .iterations      (iterations),
    .busy            (busy),
    .result          (result)
  );

  result_reader u_result_reader (
    .clk_main_a0     (clk_main_a0),
    .rst_main_n_sync (rst_main_n_sync),
    .data_rd         (data_rd),
    .result          (result),
    .rd_word         (rd_word)
  );

endmodule

`default_nettype wire

// File: tests/matvec_accel_tb.sv
// Table-driven testbench for the matrix-vector accelerator, loads operands over AXI-Lite and checks reads
`default_nettype none

module matvec_accel_tb;
  timeunit 1ns;
  timeprecision 100ps;

  import matvec_pkg::*;
  import axil_pkg::*;

  localparam int    TIMEOUT_CYCLES    = 200;
  localparam int    IDLE_CHECK_CYCLES = 40;
  localparam int    NUM_ROWS          = 6;
  // Unmapped register for stray writes and reads
  localparam addr_t OTHER_ADDR        = 32'h0000_0504;

  // One stimulus row
  typedef struct packed {
    iter_t      iters;
    vec_t       vec;
    logic       rand_mat;
    logic       stray_write;
    logic       unimpl_read;
    logic [3:0] rd_hold;
  } stim_t;

  logic       clk_main_a0;
  logic       rst_main_n_sync;
  logic       awvalid;
  addr_t      awaddr;
  logic       awready;
  logic       wvalid;
  word_t      wdata;
  logic [3:0] wstrb;
  logic       wready;
  logic       bvalid;
  resp_t      bresp;
  logic       bready;
  logic       arvalid;
  addr_t      araddr;
  logic       arready;
  logic       rvalid;
  word_t      rdata;
  resp_t      rresp;
  logic       rready;
  logic       busy;

  stim_t  stim_tbl [NUM_ROWS];
  // Reference copy of the loaded matrix, element (j, k) at j*16+k
  elem_t  model_mat [DIM*DIM];
  vec_t   exp_vec;
  integer seed;

  matvec_accel_top uut (.*);

  // 100 ns clock
  initial clk_main_a0 = 1'b0;
  always #50 clk_main_a0 = ~clk_main_a0;

  // --------------------------------------------------
  // Error reporting
  // --------------------------------------------------
  task automatic report_and_stop();
    $display("Verification failed");
    $fatal(1, "Simulation stopped at first error");
  endtask

  task automatic check_word(input string name, input logic [31:0] got, input logic [31:0] exp);
    assert (got === exp) else begin
      $display("[FAIL] %s got 0x%h expected 0x%h", name, got, exp);
      report_and_stop();
    end
  endtask

  task automatic check_cond(input logic cond, input string what);
    assert (cond === 1'b1) else begin
      $display("Error: %s", what);
      report_and_stop();
    end
  endtask

  // One more cycle spent waiting, gives up past the limit
  task automatic count_wait(inout int cnt, input int limit, input string what);
    cnt++;
    if (cnt > limit) begin
      $display("Timeout: %s", what);
      report_and_stop();
    end
  endtask

  // --------------------------------------------------
  // Bus access, entered and left 1 ns after a rising edge
  // --------------------------------------------------
  task automatic bus_write(input addr_t addr, input word_t data);
    int cnt;
    awvalid = 1'b1;
    awaddr  = addr;
    wvalid  = 1'b1;
    wdata   = data;
    bready  = 1'b1;
    // Address phase
    cnt = 0;
    @(negedge clk_main_a0);
    while (!awready) begin
      count_wait(cnt, TIMEOUT_CYCLES, "awready stayed low");
      @(negedge clk_main_a0);
    end
    @(posedge clk_main_a0);
    #1 awvalid = 1'b0;
    // Data phase
    cnt = 0;
    @(negedge clk_main_a0);
    while (!wready) begin
      count_wait(cnt, TIMEOUT_CYCLES, "wready stayed low");
      @(negedge clk_main_a0);
    end
    @(posedge clk_main_a0);
    #1 wvalid = 1'b0;
    // Response
    cnt = 0;
    @(negedge clk_main_a0);
    while (!bvalid) begin
      count_wait(cnt, TIMEOUT_CYCLES, "bvalid stayed low");
      @(negedge clk_main_a0);
    end
    check_word("bresp", 32'(bresp), 32'(RESP_OKAY));
    @(posedge clk_main_a0);
    #1 bready = 1'b0;
  endtask

  // hold is the number of cycles rready stays low once rvalid is up
  task automatic bus_read(input addr_t addr, input int hold, output word_t data);
    int    cnt;
    word_t first;
    arvalid = 1'b1;
    araddr  = addr;
    rready  = (hold == 0);
    cnt = 0;
    @(negedge clk_main_a0);
    while (!arready) begin
      count_wait(cnt, TIMEOUT_CYCLES, "arready stayed low");
      @(negedge clk_main_a0);
    end
    @(posedge clk_main_a0);
    #1 arvalid = 1'b0;
    cnt = 0;
    @(negedge clk_main_a0);
    while (!rvalid) begin
      count_wait(cnt, TIMEOUT_CYCLES, "rvalid stayed low");
      @(negedge clk_main_a0);
    end
    first = rdata;
    // Back-pressure, data must not move
    for (int i = 0; i < hold; i++) begin
      @(negedge clk_main_a0);
      check_cond(rvalid, "rvalid dropped while rready was low");
      check_word("rdata", rdata, first);
    end
    if (hold != 0) begin
      @(posedge clk_main_a0);
      #1 rready = 1'b1;
      @(negedge clk_main_a0);
      check_cond(rvalid, "rvalid dropped before rready rose");
    end
    data = rdata;
    check_word("rresp", 32'(rresp), 32'(RESP_OKAY));
    @(posedge clk_main_a0);
    #1 rready = 1'b0;
  endtask

  // --------------------------------------------------
  // Load sequence and run wait
  // --------------------------------------------------
  task automatic load_operands(input stim_t row);
    word_t w;
    int    e;
    for (int n = 0; n < MAT_WORDS; n++) begin
      if (row.rand_mat) begin
        w = $random(seed);
        for (int b = 0; b < 4; b++) begin
          model_mat[n*4+b] = w[b*8 +: 8];
        end
      end else begin
        // Identity
        for (int b = 0; b < 4; b++) begin
          e = n*4 + b;
          model_mat[e] = (e / DIM == e % DIM) ? 8'd1 : 8'd0;
          w[b*8 +: 8] = model_mat[e];
        end
      end
      bus_write(DATA_REG_ADDR, w);
      // Unmapped write halfway through the matrix
      if (row.stray_write && n == MAT_WORDS / 2) begin
        bus_write(OTHER_ADDR, 32'hFFFF_FFFF);
      end
    end
    for (int v = 0; v < VEC_WORDS; v++) begin
      bus_write(DATA_REG_ADDR, row.vec[v*32 +: 32]);
    end
    // Count write starts the run
    bus_write(DATA_REG_ADDR, row.iters);
  endtask

  task automatic wait_run(input iter_t iters);
    int cnt;
    cnt = 0;
    @(negedge clk_main_a0);
    if (iters == '0) begin
      while (cnt < IDLE_CHECK_CYCLES) begin
        check_cond(!busy, "busy rose for a zero iteration count");
        cnt++;
        @(negedge clk_main_a0);
      end
    end else begin
      while (!busy) begin
        count_wait(cnt, TIMEOUT_CYCLES, "busy never rose");
        @(negedge clk_main_a0);
      end
      cnt = 0;
      while (busy) begin
        count_wait(cnt, 16 * int'(iters) + TIMEOUT_CYCLES, "busy never fell");
        @(negedge clk_main_a0);
      end
    end
    @(posedge clk_main_a0);
    #1;
  endtask

  // Repeated product, every product and sum kept to 8 bits
  function automatic vec_t model_run(input vec_t v_in, input iter_t iters);
    vec_t  v;
    vec_t  nv;
    elem_t acc;
    v  = v_in;
    nv = '0;
    for (int n = 0; n < int'(iters); n++) begin
      for (int j = 0; j < DIM; j++) begin
        acc = '0;
        for (int k = 0; k < DIM; k++) begin
          acc = acc + model_mat[j*DIM+k] * v[k*ELEM_W +: ELEM_W];
        end
        nv[j*ELEM_W +: ELEM_W] = acc;
      end
      v = nv;
    end
    return v;
  endfunction

  // --------------------------------------------------
  // Main sequence
  // --------------------------------------------------
  initial begin
    word_t got;
    seed            = 32'h1c3471f2;
    rst_main_n_sync = 1'b0;
    awvalid         = 1'b0;
    awaddr          = '0;
    wvalid          = 1'b0;
    wdata           = '0;
    wstrb           = 4'hF;
    bready          = 1'b0;
    arvalid         = 1'b0;
    araddr          = '0;
    rready          = 1'b0;
    exp_vec         = '0;

    // Columns: iterations, vector, random matrix, stray write, unmapped read, read hold
    stim_tbl[0] = '{32'd1, 128'h0f1e_2d3c_4b5a_6978_8796_a5b4_c3d2_e1f0, 1'b1, 1'b0, 1'b1, 4'd0};
    stim_tbl[1] = '{32'd3, 128'h1234_5678_9abc_def0_fedc_ba98_7654_3210, 1'b0, 1'b1, 1'b0, 4'd0};
    stim_tbl[2] = '{32'd2, 128'hffee_ddcc_bbaa_9988_7766_5544_3322_1100, 1'b1, 1'b0, 1'b0, 4'd6};
    // Zero count, result of row 2 stays
    stim_tbl[3] = '{32'd0, 128'h0101_0202_0303_0404_0505_0606_0707_0808, 1'b1, 1'b1, 1'b1, 4'd0};
    stim_tbl[4] = '{32'd5, 128'h8080_7f7f_0102_0304_c0de_cafe_5a5a_a5a5, 1'b1, 1'b0, 1'b1, 4'd3};
    stim_tbl[5] = '{32'd4, 128'h0011_2233_4455_6677_8899_aabb_ccdd_eeff, 1'b0, 1'b0, 1'b0, 4'd2};

    repeat (5) @(posedge clk_main_a0);
    #1 rst_main_n_sync = 1'b1;
    @(negedge clk_main_a0);
    check_cond(!busy && !bvalid && !rvalid, "busy, bvalid or rvalid was high after reset");
    check_cond(awready && arready, "awready or arready was low after reset");
    @(posedge clk_main_a0);
    #1;

    // Result is zero out of reset
    for (int i = 0; i < VEC_WORDS; i++) begin
      bus_read(DATA_REG_ADDR, 0, got);
      check_word("rdata", got, '0);
    end

    for (int r = 0; r < NUM_ROWS; r++) begin
      load_operands(stim_tbl[r]);
      wait_run(stim_tbl[r].iters);
      if (stim_tbl[r].iters != '0) begin
        exp_vec = model_run(stim_tbl[r].vec, stim_tbl[r].iters);
      end
      // Unmapped read leaves the word pointer alone
      if (stim_tbl[r].unimpl_read) begin
        bus_read(OTHER_ADDR, 0, got);
        check_word("rdata", got, UNIMPL_VALUE);
      end
      for (int i = 0; i < VEC_WORDS; i++) begin
        // Back-pressure on the second word
        bus_read(DATA_REG_ADDR, (i == 1) ? int'(stim_tbl[r].rd_hold) : 0, got);
        check_word("rdata", got, exp_vec[i*32 +: 32]);
      end
    end

    $display("Verification passed");
    $finish;
  end

endmodule

`default_nettype wire

// File: sources.f
logic/matvec_pkg.sv
logic/axil_pkg.sv
logic/axil_slave_port.sv
logic/operand_loader.sv
logic/matvec_engine.sv
logic/result_reader.sv
logic/matvec_accel_top.sv
tests/matvec_accel_tb.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing -j 0
TOP       ?= matvec_accel_tb
FILELIST  ?= sources.f
OBJ_DIR   ?= obj_dir
SIM_BIN   := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: compile
	@out="$$(./$(SIM_BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "Verification passed"

clean:
	rm -rf $(OBJ_DIR)
